// ==== source/exe_pkg.sv ====
package exe_pkg;

	// Register index and shift amount widths
	localparam int unsigned RegAddrWidth = 5;
	localparam int unsigned ShamtWidth   = 5; // Covers 0..31 for 32-bit data
	localparam int unsigned InstrBytes   = 4; // Sequential PC step

	// Decoded operation handed in by the decode stage
	typedef enum logic [4:0] {
		OP_ADD   = 5'd0,
		OP_SUB   = 5'd1,
		OP_AND   = 5'd2,
		OP_OR    = 5'd3,
		OP_XOR   = 5'd4,
		OP_SLT   = 5'd5,  // Signed compare
		OP_SLTU  = 5'd6,  // Unsigned compare
		OP_SLL   = 5'd7,
		OP_SRL   = 5'd8,
		OP_SRA   = 5'd9,
		OP_LUI   = 5'd10, // b carries the shifted immediate
		OP_AUIPC = 5'd11,
		OP_JAL   = 5'd12,
		OP_JALR  = 5'd13,
		OP_BEQ   = 5'd14,
		OP_BNE   = 5'd15,
		OP_BLT   = 5'd16,
		OP_BGE   = 5'd17,
		OP_BLTU  = 5'd18,
		OP_BGEU  = 5'd19
	} exe_op_e;

	// Shifter implementation choice
	typedef enum logic {
		SHIFT_SEQUENTIAL = 1'b0, // One bit per cycle
		SHIFT_BARREL     = 1'b1  // Full shift in one cycle
	} shift_style_e;

	// Shift kind requested by the controller
	typedef enum logic [1:0] {
		SHIFT_NONE   = 2'd0,
		SHIFT_LEFT   = 2'd1,
		SHIFT_RIGHT  = 2'd2,
		SHIFT_ARIGHT = 2'd3
	} shift_dir_e;

	// Controller FSM
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // Waiting for an instruction
		ST_SHIFT = 2'd1, // Shifter busy
		ST_DONE  = 2'd2  // Result ready for writeback
	} exe_state_e;

endpackage

// ==== source/exe_ctrl.sv ====
`timescale 1ns/1ps

module exe_ctrl #(
	parameter int unsigned DataWidth = 32
) (
	input  logic                              clk_i,
	input  logic                              rstn_i,
	input  logic                              in_valid_i,
	output logic                              in_ready_o,
	input  exe_pkg::exe_op_e                  op_i,
	input  logic [DataWidth-1:0]              a_i,
	input  logic [DataWidth-1:0]              b_i,
	input  logic [DataWidth-1:0]              pc_i,
	input  logic [DataWidth-1:0]              imm_i,
	input  logic [exe_pkg::RegAddrWidth-1:0]  rd_i,
	output exe_pkg::exe_op_e                  op_o,
	output logic [DataWidth-1:0]              a_o,
	output logic [DataWidth-1:0]              b_o,
	output logic [DataWidth-1:0]              pc_o,
	output logic [DataWidth-1:0]              imm_o,
	input  logic [DataWidth-1:0]              alu_result_i,
	output logic                              shift_start_o,
	output exe_pkg::shift_dir_e               shift_dir_o,
	input  logic                              shift_done_i,
	input  logic [DataWidth-1:0]              shift_result_i,
	input  logic [DataWidth-1:0]              link_i,
	input  logic [DataWidth-1:0]              next_pc_i,
	input  logic                              taken_i,
	input  logic                              wb_free_i,
	output logic                              wb_load_o,
	output logic [DataWidth-1:0]              wb_result_o,
	output logic [exe_pkg::RegAddrWidth-1:0]  wb_rd_o,
	output logic                              wb_we_o,
	output logic [DataWidth-1:0]              wb_next_pc_o,
	output logic                              wb_taken_o
);
	import exe_pkg::*;

	exe_state_e                state_q;
	exe_op_e                   op_q;      // Latched instruction
	logic [DataWidth-1:0]      a_q, b_q, pc_q, imm_q;
	logic [RegAddrWidth-1:0]   rd_q;
	logic                      accept;
	logic                      idle;
	logic                      is_branch;
	shift_dir_e                start_dir;

	assign idle       = (state_q == ST_IDLE);
	assign in_ready_o = idle && wb_free_i; // One item here, one in writeback
	assign accept     = in_valid_i && in_ready_o;

	// Live inputs while idle so the shifter captures on the accepting edge
	assign op_o  = idle ? op_i  : op_q;
	assign a_o   = idle ? a_i   : a_q;
	assign b_o   = idle ? b_i   : b_q;
	assign pc_o  = idle ? pc_i  : pc_q;
	assign imm_o = idle ? imm_i : imm_q;

	always_comb begin : start_decode
		case (op_i)
			OP_SLL:  start_dir = SHIFT_LEFT;
			OP_SRL:  start_dir = SHIFT_RIGHT;
			OP_SRA:  start_dir = SHIFT_ARIGHT;
			default: start_dir = SHIFT_NONE;
		endcase
	end

	assign shift_start_o = accept && (start_dir != SHIFT_NONE);
	assign shift_dir_o   = start_dir;

	always_ff @(posedge clk_i) begin : fsm
		if (!rstn_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE:  if (accept) state_q <= (start_dir != SHIFT_NONE) ? ST_SHIFT : ST_DONE;
				ST_SHIFT: if (shift_done_i && wb_free_i) state_q <= ST_IDLE;
				ST_DONE:  if (wb_free_i) state_q <= ST_IDLE;
				default:  state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin : instr_latch
		if (accept) begin
			op_q  <= op_i;
			a_q   <= a_i;
			b_q   <= b_i;
			pc_q  <= pc_i;
			imm_q <= imm_i;
			rd_q  <= rd_i;
		end
	end

	// Result source by op class
	always_comb begin : result_sel
		is_branch   = 1'b0;
		wb_result_o = alu_result_i;
		case (op_q)
			OP_SLL, OP_SRL, OP_SRA: wb_result_o = shift_result_i;
			OP_JAL, OP_JALR:        wb_result_o = link_i; // Return address
			OP_AUIPC:               wb_result_o = b_q + pc_q;
			OP_LUI:                 wb_result_o = b_q;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: is_branch = 1'b1;
			default:                wb_result_o = alu_result_i;
		endcase
	end

	assign wb_load_o    = wb_free_i &&
		((state_q == ST_DONE) || ((state_q == ST_SHIFT) && shift_done_i));
	assign wb_rd_o      = rd_q;
	assign wb_we_o      = !is_branch && (rd_q != '0); // x0 never written
	assign wb_next_pc_o = next_pc_i;
	assign wb_taken_o   = taken_i;

endmodule

// ==== source/exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu #(
	parameter int unsigned DataWidth = 32
) (
	input  exe_pkg::exe_op_e       op_i,
	input  logic [DataWidth-1:0]   a_i,
	input  logic [DataWidth-1:0]   b_i,
	output logic [DataWidth-1:0]   result_o,
	output logic                   eq_o,
	output logic                   lt_o,
	output logic                   ltu_o
);
	import exe_pkg::*;

	logic [DataWidth-1:0] sum;
	logic [DataWidth-1:0] diff;

	assign sum  = a_i + b_i;
	assign diff = a_i - b_i;

	// Compare flags, shared by SLT/SLTU and the branch unit
	assign eq_o  = (a_i == b_i);
	assign lt_o  = ($signed(a_i) < $signed(b_i));
	assign ltu_o = (a_i < b_i);

	always_comb begin : alu_op
		case (op_i)
			OP_ADD: begin
				result_o = sum;
			end
			OP_SUB: begin
				result_o = diff;
			end
			OP_AND: begin
				result_o = a_i & b_i;
			end
			OP_OR: begin
				result_o = a_i | b_i;
			end
			OP_XOR: begin
				result_o = a_i ^ b_i;
			end
			OP_SLT: begin
				result_o = {{(DataWidth-1){1'b0}}, lt_o}; // Zero extended flag
			end
			OP_SLTU: begin
				result_o = {{(DataWidth-1){1'b0}}, ltu_o};
			end
			default: begin
				result_o = sum; // Unused by non-ALU ops
			end
		endcase
	end

endmodule

// ==== source/exe_shifter.sv ====
`timescale 1ns/1ps

module exe_shifter #(
	parameter int unsigned           DataWidth  = 32,
	parameter exe_pkg::shift_style_e ShiftStyle = exe_pkg::SHIFT_SEQUENTIAL
) (
	input  logic                            clk_i,
	input  logic                            rstn_i,
	input  logic                            start_i,
	input  exe_pkg::shift_dir_e             dir_i,
	input  logic [DataWidth-1:0]            value_i,
	input  logic [exe_pkg::ShamtWidth-1:0]  amount_i,
	output logic                            done_o,
	output logic [DataWidth-1:0]            result_o
);
	import exe_pkg::*;

	logic [DataWidth-1:0] work_q; // Shift working register
	logic                 done_q; // Held until the next start

	assign result_o = work_q;
	assign done_o   = done_q;

	if (ShiftStyle == SHIFT_BARREL) begin : g_barrel
		always_ff @(posedge clk_i) begin
			if (!rstn_i) begin
				done_q <= 1'b0;
			end else if (start_i) begin
				done_q <= 1'b1; // Whole shift in this cycle
				case (dir_i)
					SHIFT_LEFT:   work_q <= value_i << amount_i;
					SHIFT_RIGHT:  work_q <= value_i >> amount_i;
					SHIFT_ARIGHT: work_q <= $signed(value_i) >>> amount_i;
					default:      work_q <= value_i;
				endcase
			end
		end
	end else begin : g_sequential
		shift_dir_e            dir_q;
		logic [ShamtWidth-1:0] cnt_q; // Remaining bit positions
		logic                  run_q;

		always_ff @(posedge clk_i) begin
			if (!rstn_i) begin
				done_q <= 1'b0;
				run_q  <= 1'b0;
				cnt_q  <= '0;
			end else if (start_i) begin
				work_q <= value_i;
				dir_q  <= dir_i;
				cnt_q  <= amount_i;
				run_q  <= (amount_i != '0);
				done_q <= (amount_i == '0); // Zero amount passes value through
			end else if (run_q) begin
				case (dir_q)
					SHIFT_LEFT:   work_q <= {work_q[DataWidth-2:0], 1'b0};
					SHIFT_RIGHT:  work_q <= {1'b0, work_q[DataWidth-1:1]};
					SHIFT_ARIGHT: work_q <= {work_q[DataWidth-1], work_q[DataWidth-1:1]};
					default:      work_q <= work_q;
				endcase
				cnt_q <= cnt_q - ShamtWidth'(1);
				if (cnt_q == ShamtWidth'(1)) begin // Last bit this cycle
					run_q  <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== source/exe_branch.sv ====
`timescale 1ns/1ps

module exe_branch #(
	parameter int unsigned DataWidth = 32
) (
	input  exe_pkg::exe_op_e       op_i,
	input  logic [DataWidth-1:0]   pc_i,
	input  logic [DataWidth-1:0]   a_i,
	input  logic [DataWidth-1:0]   imm_i,
	input  logic                   eq_i,
	input  logic                   lt_i,
	input  logic                   ltu_i,
	output logic [DataWidth-1:0]   next_pc_o,
	output logic [DataWidth-1:0]   link_o,
	output logic                   taken_o
);
	import exe_pkg::*;

	logic [DataWidth-1:0] pc_rel;   // Branch and JAL target
	logic [DataWidth-1:0] reg_rel;  // JALR base plus offset
	logic [DataWidth-1:0] target;
	logic [DataWidth-1:0] pc_seq;

	assign pc_rel  = pc_i + imm_i;
	assign reg_rel = a_i + imm_i;
	assign pc_seq  = pc_i + DataWidth'(InstrBytes);

	// JALR drops the low bit of the computed address
	assign target = (op_i == OP_JALR) ? {reg_rel[DataWidth-1:1], 1'b0} : pc_rel;

	always_comb begin : cond_eval
		case (op_i)
			OP_BEQ:          taken_o = eq_i;
			OP_BNE:          taken_o = !eq_i;
			OP_BLT:          taken_o = lt_i;
			OP_BGE:          taken_o = !lt_i;
			OP_BLTU:         taken_o = ltu_i;
			OP_BGEU:         taken_o = !ltu_i;
			OP_JAL, OP_JALR: taken_o = 1'b1; // Unconditional
			default:         taken_o = 1'b0;
		endcase
	end

	assign next_pc_o = taken_o ? target : pc_seq;
	assign link_o    = pc_seq; // Return address for jumps

endmodule

// ==== source/exe_writeback.sv ====
`timescale 1ns/1ps

module exe_writeback #(
	parameter int unsigned DataWidth = 32
) (
	input  logic                              clk_i,
	input  logic                              rstn_i,
	input  logic                              load_i,
	input  logic [DataWidth-1:0]              result_i,
	input  logic [exe_pkg::RegAddrWidth-1:0]  rd_i,
	input  logic                              we_i,
	input  logic [DataWidth-1:0]              next_pc_i,
	input  logic                              taken_i,
	input  logic                              out_ready_i,
	output logic                              free_o,
	output logic                              out_valid_o,
	output logic [DataWidth-1:0]              result_o,
	output logic [exe_pkg::RegAddrWidth-1:0]  rd_o,
	output logic                              we_o,
	output logic [DataWidth-1:0]              next_pc_o,
	output logic                              taken_o
);

	logic full_q;

	// Empty, or being drained on this edge
	assign free_o      = !full_q || out_ready_i;
	assign out_valid_o = full_q;

	always_ff @(posedge clk_i) begin : valid_ctrl
		if (!rstn_i) begin
			full_q  <= 1'b0;
			we_o    <= 1'b0;
			taken_o <= 1'b0;
		end else if (load_i) begin
			full_q  <= 1'b1; // Refill wins over drain
			we_o    <= we_i;
			taken_o <= taken_i;
		end else if (out_ready_i) begin
			full_q <= 1'b0;
		end
	end

	// Payload only moves on load so it stays stable while stalled
	always_ff @(posedge clk_i) begin : payload
		if (load_i) begin
			result_o  <= result_i;
			rd_o      <= rd_i;
			next_pc_o <= next_pc_i;
		end
	end

endmodule

// ==== source/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage #(
	parameter int unsigned           DataWidth  = 32,
	parameter exe_pkg::shift_style_e ShiftStyle = exe_pkg::SHIFT_SEQUENTIAL
) (
	input  logic                              clk_i,
	input  logic                              rstn_i,
	input  logic                              in_valid_i,
	output logic                              in_ready_o,
	input  exe_pkg::exe_op_e                  op_i,
	input  logic [DataWidth-1:0]              a_i,
	input  logic [DataWidth-1:0]              b_i,
	input  logic [DataWidth-1:0]              pc_i,
	input  logic [DataWidth-1:0]              imm_i,
	input  logic [exe_pkg::RegAddrWidth-1:0]  rd_i,
	output logic                              out_valid_o,
	input  logic                              out_ready_i,
	output logic [DataWidth-1:0]              result_o,
	output logic [exe_pkg::RegAddrWidth-1:0]  rd_o,
	output logic                              we_o,
	output logic [DataWidth-1:0]              next_pc_o,
	output logic                              taken_o
);
	import exe_pkg::*;

	exe_op_e                 op;
	logic [DataWidth-1:0]    a, b, pc, imm;        // Operands from the controller
	logic [DataWidth-1:0]    alu_result, shift_result;
	logic                    eq, lt, ltu;          // ALU compare flags
	logic                    shift_start, shift_done;
	shift_dir_e              shift_dir;
	logic [DataWidth-1:0]    link, next_pc;
	logic                    taken;
	logic                    wb_free, wb_load, wb_we, wb_taken;
	logic [DataWidth-1:0]    wb_result, wb_next_pc;
	logic [RegAddrWidth-1:0] wb_rd;

	exe_ctrl #(.DataWidth(DataWidth)) ctrl_i (
		.clk_i(clk_i), .rstn_i(rstn_i),
		.in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
		.op_i(op_i), .a_i(a_i), .b_i(b_i), .pc_i(pc_i), .imm_i(imm_i), .rd_i(rd_i),
		.op_o(op), .a_o(a), .b_o(b), .pc_o(pc), .imm_o(imm),
		.alu_result_i(alu_result),
		.shift_start_o(shift_start), .shift_dir_o(shift_dir),
		.shift_done_i(shift_done), .shift_result_i(shift_result),
		.link_i(link), .next_pc_i(next_pc), .taken_i(taken),
		.wb_free_i(wb_free), .wb_load_o(wb_load),
		.wb_result_o(wb_result), .wb_rd_o(wb_rd), .wb_we_o(wb_we),
		.wb_next_pc_o(wb_next_pc), .wb_taken_o(wb_taken)
	);

	exe_alu #(.DataWidth(DataWidth)) alu_i (
		.op_i(op), .a_i(a), .b_i(b),
		.result_o(alu_result), .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
	);

	// Shift amount is the low bits of operand b
	exe_shifter #(.DataWidth(DataWidth), .ShiftStyle(ShiftStyle)) shifter_i (
		.clk_i(clk_i), .rstn_i(rstn_i),
		.start_i(shift_start), .dir_i(shift_dir),
		.value_i(a), .amount_i(b[ShamtWidth-1:0]),
		.done_o(shift_done), .result_o(shift_result)
	);

	exe_branch #(.DataWidth(DataWidth)) branch_i (
		.op_i(op), .pc_i(pc), .a_i(a), .imm_i(imm),
		.eq_i(eq), .lt_i(lt), .ltu_i(ltu),
		.next_pc_o(next_pc), .link_o(link), .taken_o(taken)
	);

	exe_writeback #(.DataWidth(DataWidth)) writeback_i (
		.clk_i(clk_i), .rstn_i(rstn_i),
		.load_i(wb_load), .result_i(wb_result), .rd_i(wb_rd), .we_i(wb_we),
		.next_pc_i(wb_next_pc), .taken_i(wb_taken),
		.out_ready_i(out_ready_i), .free_o(wb_free), .out_valid_o(out_valid_o),
		.result_o(result_o), .rd_o(rd_o), .we_o(we_o),
		.next_pc_o(next_pc_o), .taken_o(taken_o)
	);

endmodule

// ==== test/exe_stage_tb.sv ====
`timescale 1ns/1ps

module exe_stage_tb;
	import exe_pkg::*;

	localparam int NumInstr    = 60 + 96 + 24 + 16 + 150; // All phases together
	localparam int MaxShiftLat = 33;                      // 31 bits plus 2 cycles
	localparam int CycleLimit  = 2 * MaxShiftLat * NumInstr + 200;

	typedef struct packed {
		exe_op_e     op;
		logic [31:0] result;
		logic [4:0]  rd;
		logic        we;
		logic [31:0] next_pc;
		logic        taken;
		logic        chk_result; // Branch results are don't care
	} expect_t;

	logic        clk_i = 1'b0;
	logic        rstn_i;
	logic        in_valid_i;
	logic        in_ready_o;
	exe_op_e     op_i;
	logic [31:0] a_i, b_i, pc_i, imm_i;
	logic [4:0]  rd_i;
	logic        out_valid_o;
	logic        out_ready_i;
	logic [31:0] result_o, next_pc_o;
	logic [4:0]  rd_o;
	logic        we_o, taken_o;

	logic [15:0] lfsr_q;
	logic        stall_en;
	string       test_name = "reset";
	expect_t     exp_q[$];   // Accepted, not yet seen at the output
	int          sent_count = 0;
	int          recv_count = 0;
	int          cycle_count = 0;
	logic        held_valid = 1'b0;
	logic [31:0] held_result, held_next_pc;
	logic [4:0]  held_rd;
	logic        held_we, held_taken;

	exe_stage #(.DataWidth(32), .ShiftStyle(SHIFT_SEQUENTIAL)) dut_i (
		.clk_i(clk_i), .rstn_i(rstn_i),
		.in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
		.op_i(op_i), .a_i(a_i), .b_i(b_i), .pc_i(pc_i), .imm_i(imm_i), .rd_i(rd_i),
		.out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
		.result_o(result_o), .rd_o(rd_o), .we_o(we_o),
		.next_pc_o(next_pc_o), .taken_o(taken_o)
	);

	always #10 clk_i = ~clk_i; // 20 ns period

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q); // One step per bit
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Expected outputs straight from the ISA rules
	function automatic expect_t ref_model(input exe_op_e op, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm,
			input logic [4:0] rd);
		expect_t     e;
		logic [31:0] seq;
		logic        br;
		seq          = pc + 32'd4;
		br           = 1'b0;
		e.op         = op;
		e.rd         = rd;
		e.result     = '0;
		e.taken      = 1'b0;
		e.next_pc    = seq; // Fall through by default
		e.chk_result = 1'b1;
		case (op)
			OP_ADD:   e.result = a + b;
			OP_SUB:   e.result = a - b;
			OP_AND:   e.result = a & b;
			OP_OR:    e.result = a | b;
			OP_XOR:   e.result = a ^ b;
			OP_SLT:   e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_SLTU:  e.result = (a < b) ? 32'd1 : 32'd0;
			OP_SLL:   e.result = a << b[4:0];
			OP_SRL:   e.result = a >> b[4:0];
			OP_SRA:   e.result = $signed(a) >>> b[4:0];
			OP_LUI:   e.result = b;
			OP_AUIPC: e.result = pc + b;
			OP_JAL: begin
				e.result  = seq;
				e.taken   = 1'b1;
				e.next_pc = pc + imm;
			end
			OP_JALR: begin
				e.result  = seq;
				e.taken   = 1'b1;
				e.next_pc = (a + imm) & ~32'd1; // Low bit cleared
			end
			OP_BEQ:  begin br = 1'b1; e.taken = (a == b); end
			OP_BNE:  begin br = 1'b1; e.taken = (a != b); end
			OP_BLT:  begin br = 1'b1; e.taken = ($signed(a) < $signed(b)); end
			OP_BGE:  begin br = 1'b1; e.taken = ($signed(a) >= $signed(b)); end
			OP_BLTU: begin br = 1'b1; e.taken = (a < b); end
			OP_BGEU: begin br = 1'b1; e.taken = (a >= b); end
			default: e.result = '0;
		endcase
		if (br) begin
			e.chk_result = 1'b0;
			if (e.taken)
				e.next_pc = pc + imm;
		end
		e.we = !br && (rd != 5'd0); // x0 and branches never write
		return e;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
				test_name, what, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Value mismatch on %s", what);
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "Run aborted");
	endtask

	always @(posedge clk_i) begin : watchdog
		cycle_count <= cycle_count + 1;
		if (cycle_count > CycleLimit)
			fail_run($sformatf("Timeout: run did not finish in %0d cycles", CycleLimit));
	end

	// Sampled mid-cycle where handshakes are settled
	always @(negedge clk_i) begin : compare_outputs
		expect_t e;
		if (!rstn_i) begin
			held_valid = 1'b0;
		end else begin
			if (held_valid) begin // Stalled last cycle so nothing may move
				check_value("hold valid", 32'd1, 32'(out_valid_o));
				check_value("hold result", held_result, result_o);
				check_value("hold rd", 32'(held_rd), 32'(rd_o));
				check_value("hold we", 32'(held_we), 32'(we_o));
				check_value("hold next_pc", held_next_pc, next_pc_o);
				check_value("hold taken", 32'(held_taken), 32'(taken_o));
			end
			if (in_valid_i && in_ready_o) begin
				exp_q.push_back(ref_model(op_i, a_i, b_i, pc_i, imm_i, rd_i));
				sent_count++;
			end
			if (out_valid_o && out_ready_i) begin
				if (exp_q.size() == 0)
					fail_run("Output transfer without any pending instruction");
				e = exp_q.pop_front();
				if (e.chk_result)
					check_value({e.op.name(), " result"}, e.result, result_o);
				check_value({e.op.name(), " rd"}, 32'(e.rd), 32'(rd_o));
				check_value({e.op.name(), " we"}, 32'(e.we), 32'(we_o));
				check_value({e.op.name(), " next_pc"}, e.next_pc, next_pc_o);
				check_value({e.op.name(), " taken"}, 32'(e.taken), 32'(taken_o));
				recv_count++;
			end
			held_valid   = out_valid_o && !out_ready_i;
			held_result  = result_o;
			held_rd      = rd_o;
			held_we      = we_o;
			held_next_pc = next_pc_o;
			held_taken   = taken_o;
		end
	end

	task automatic update_ready();
		logic [31:0] r;
		if (stall_en) begin
			r           = take_bits(2);
			out_ready_i = (r[1:0] != 2'd0); // Stall one cycle in four
		end else begin
			out_ready_i = 1'b1;
		end
	endtask

	// Called 2 ns after a rising edge, returns at the same point
	task automatic send_instr(input exe_op_e op, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] pc, input logic [31:0] imm, input logic [4:0] rd);
		logic fired;
		op_i       = op;
		a_i        = a;
		b_i        = b;
		pc_i       = pc;
		imm_i      = imm;
		rd_i       = rd;
		in_valid_i = 1'b1;
		fired      = 1'b0;
		while (!fired) begin
			@(negedge clk_i);
			fired = in_ready_o; // Transfer on the coming edge
			@(posedge clk_i);
			#2;
			update_ready();
		end
		in_valid_i = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk_i);
			#2;
			update_ready();
		end
	endtask

	task automatic random_operands(output logic [31:0] a, output logic [31:0] b,
			output logic [31:0] pc, output logic [31:0] imm, output logic [4:0] rd);
		logic [31:0] r;
		a   = take_bits(32);
		b   = take_bits(32);
		imm = take_bits(32);
		r   = take_bits(30);
		pc  = {r[29:0], 2'b00}; // Word aligned
		r   = take_bits(5);
		rd  = r[4:0];
		r   = take_bits(3);
		if (r[2:0] == 3'd0)
			rd = 5'd0; // Exercise the x0 write suppression
	endtask

	function automatic exe_op_e alu_class_op(input logic [3:0] sel);
		case (sel)
			4'd0:    return OP_ADD;
			4'd1:    return OP_SUB;
			4'd2:    return OP_AND;
			4'd3:    return OP_OR;
			4'd4:    return OP_XOR;
			4'd5:    return OP_SLT;
			4'd6:    return OP_SLTU;
			4'd7:    return OP_LUI;
			default: return OP_AUIPC;
		endcase
	endfunction

	initial begin : stimulus
		logic [31:0] a, b, pc, imm, r;
		logic [4:0]  rd;
		logic [4:0]  code;
		int          i;
		int          k;
		lfsr_q      = 16'd28009;
		stall_en    = 1'b0;
		rstn_i      = 1'b0;
		in_valid_i  = 1'b0;
		op_i        = OP_ADD;
		a_i         = '0;
		b_i         = '0;
		pc_i        = '0;
		imm_i       = '0;
		rd_i        = '0;
		out_ready_i = 1'b1;
		repeat (10) @(posedge clk_i);
		#2;
		rstn_i = 1'b1;
		@(negedge clk_i);
		check_value("out_valid after reset", 32'd0, 32'(out_valid_o));
		check_value("in_ready after reset", 32'd1, 32'(in_ready_o));
		@(posedge clk_i);
		#2;

		test_name = "alu";
		for (i = 0; i < 60; i++) begin
			random_operands(a, b, pc, imm, rd);
			r = take_bits(4) % 32'd9;
			send_instr(alu_class_op(r[3:0]), a, b, pc, imm, rd);
		end
		drain();

		test_name = "shift";
		for (i = 0; i < 96; i++) begin
			random_operands(a, b, pc, imm, rd);
			b[4:0] = 5'(i % 32); // Upper bits of b stay random
			code   = (i < 32) ? OP_SLL : (i < 64) ? OP_SRL : OP_SRA;
			send_instr(exe_op_e'(code), a, b, pc, imm, rd);
		end
		drain();

		test_name = "branch";
		for (k = 0; k < 6; k++) begin
			for (i = 0; i < 4; i++) begin
				random_operands(a, b, pc, imm, rd);
				r = take_bits(16);
				case (i)
					0:       begin a = r;            b = r;            end // Equal
					1:       begin a = r;            b = r + 32'd16;   end // Less
					2:       begin a = r + 32'd16;   b = r;            end // Greater
					default: begin a = 32'hFFFF_FF00; b = r + 32'd1;   end // Sign split
				endcase
				code = OP_BEQ + 5'(k);
				send_instr(exe_op_e'(code), a, b, pc, imm, rd);
			end
		end
		drain();

		test_name = "jump";
		for (i = 0; i < 16; i++) begin
			random_operands(a, b, pc, imm, rd);
			imm[0] = i[1]; // Odd offsets too, JALR must clear bit 0
			send_instr((i % 2 == 0) ? OP_JAL : OP_JALR, a, b, pc, imm, rd);
		end
		drain();

		test_name = "stall";
		stall_en  = 1'b1;
		for (i = 0; i < 150; i++) begin
			random_operands(a, b, pc, imm, rd);
			r = take_bits(5) % 32'd20;
			send_instr(exe_op_e'(r[4:0]), a, b, pc, imm, rd);
			r = take_bits(2);
			if (r[1:0] == 2'd0) begin // Idle gap on the input
				@(posedge clk_i);
				#2;
				update_ready();
			end
		end
		drain();

		stall_en    = 1'b0;
		out_ready_i = 1'b1;
		repeat (4) begin // Catch any stray extra output
			@(posedge clk_i);
			#2;
		end
		if (recv_count == sent_count && recv_count == NumInstr && !out_valid_o) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Sent %0d instructions but received %0d results", sent_count, recv_count);
			$display("Test FAILED");
			$fatal(1, "Output count mismatch");
		end
	end

endmodule

// ==== vlog.f ====
source/exe_pkg.sv
source/exe_ctrl.sv
source/exe_alu.sv
source/exe_shifter.sv
source/exe_branch.sv
source/exe_writeback.sv
source/exe_stage.sv
test/exe_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= exe_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
